//--- fetch_pkg.sv
package fetch_pkg;

	// data and address width
	localparam int XLEN = 32;

	// request tags wrap modulo 16
	localparam int TAG_WIDTH = 4;

	// byte distance between two instructions
	localparam int INSTR_BYTES = 4;

	// cache geometry, one 32-bit word per line
	localparam int ICACHE_LINES = 32;
	localparam int ICACHE_OFFSET_WIDTH = $clog2(INSTR_BYTES);
	localparam int ICACHE_INDEX_WIDTH = $clog2(ICACHE_LINES);
	localparam int ICACHE_TAG_WIDTH = XLEN - ICACHE_INDEX_WIDTH - ICACHE_OFFSET_WIDTH;

	typedef logic [TAG_WIDTH-1:0] tag_t;

	// major opcodes in bits [6:0] of an instruction
	typedef enum logic [6:0] {
		OP_OTHER  = 7'b0000000,
		OP_BRANCH = 7'b1100011,
		OP_JALR   = 7'b1100111,
		OP_JAL    = 7'b1101111
	} opcode_e;

	typedef enum logic [1:0] {
		FETCH_ISSUE  = 2'd0,
		FETCH_WAIT   = 2'd1,
		FETCH_BRANCH = 2'd2
	} fetch_state_e;

	typedef enum logic {
		CACHE_IDLE = 1'b0,
		CACHE_FILL = 1'b1
	} icache_state_e;

	// stage to cache, a new tag marks a new request
	typedef struct packed {
		tag_t tag;
		logic [XLEN-1:0] address;
	} fetch_req_t;

	// cache to stage, tag equals request tag once data is valid
	typedef struct packed {
		tag_t tag;
		logic [XLEN-1:0] data;
	} fetch_rsp_t;

	typedef struct packed {
		tag_t tag;
		logic [XLEN-1:0] instruction;
		logic [XLEN-1:0] pc;
	} fetch_out_t;

	// resolved control transfer from execute
	typedef struct packed {
		tag_t tag;
		logic [XLEN-1:0] pc_next;
	} redirect_t;

endpackage

//--- fetch_branch_detect.sv
module fetch_branch_detect (
	input logic [31:0] i_instruction,
	output logic o_is_branch
);

	fetch_pkg::opcode_e opcode;
	fetch_pkg::opcode_e op_class;

	// raw major opcode, may hold values outside the enum
	assign opcode = fetch_pkg::opcode_e'(i_instruction[6:0]);

	// fold everything that is not a control transfer into OP_OTHER
	always_comb begin
		case (opcode)
			fetch_pkg::OP_JAL: begin
				op_class = fetch_pkg::OP_JAL;
			end
			fetch_pkg::OP_JALR: begin
				op_class = fetch_pkg::OP_JALR;
			end
			fetch_pkg::OP_BRANCH: begin
				op_class = fetch_pkg::OP_BRANCH;
			end
			default: begin
				op_class = fetch_pkg::OP_OTHER;
			end
		endcase
	end

	// jal, jalr and conditional branches all stop the fetch stage
	assign o_is_branch = (op_class != fetch_pkg::OP_OTHER);

endmodule

//--- fetch_icache.sv
module fetch_icache (
	input logic i_clock,
	input logic i_reset,

	// request from the fetch stage, response back to it
	input fetch_pkg::fetch_req_t i_req,
	output fetch_pkg::fetch_rsp_t o_rsp,

	// word bus for line fills
	output logic o_bus_request,
	output logic [31:0] o_bus_address,
	input logic i_bus_ready,
	input logic [31:0] i_bus_rdata
);

	localparam int INDEX_LSB = fetch_pkg::ICACHE_OFFSET_WIDTH;
	localparam int INDEX_MSB = INDEX_LSB + fetch_pkg::ICACHE_INDEX_WIDTH - 1;
	localparam int TAG_LSB = INDEX_MSB + 1;

	// line storage
	logic [fetch_pkg::ICACHE_LINES-1:0] line_valid;
	logic [fetch_pkg::ICACHE_TAG_WIDTH-1:0] line_tag [fetch_pkg::ICACHE_LINES];
	logic [fetch_pkg::XLEN-1:0] line_data [fetch_pkg::ICACHE_LINES];

	fetch_pkg::icache_state_e state;

	// last request tag that has been answered
	fetch_pkg::tag_t seen_tag;
	fetch_pkg::tag_t rsp_tag;
	logic [fetch_pkg::XLEN-1:0] rsp_data;

	// lookup of the current request
	logic [fetch_pkg::ICACHE_INDEX_WIDTH-1:0] req_index;
	logic [fetch_pkg::ICACHE_TAG_WIDTH-1:0] req_addr_tag;
	logic new_request;
	logic hit;

	// line being filled, taken from the held bus address
	logic [fetch_pkg::ICACHE_INDEX_WIDTH-1:0] fill_index;
	logic [fetch_pkg::ICACHE_TAG_WIDTH-1:0] fill_addr_tag;

	assign req_index = i_req.address[INDEX_MSB:INDEX_LSB];
	assign req_addr_tag = i_req.address[fetch_pkg::XLEN-1:TAG_LSB];
	assign new_request = (i_req.tag != seen_tag);
	assign hit = line_valid[req_index] && (line_tag[req_index] == req_addr_tag);

	assign fill_index = o_bus_address[INDEX_MSB:INDEX_LSB];
	assign fill_addr_tag = o_bus_address[fetch_pkg::XLEN-1:TAG_LSB];

	assign o_rsp.tag = rsp_tag;
	assign o_rsp.data = rsp_data;

	// control: state, valid bits, tags seen and bus request level
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= fetch_pkg::CACHE_IDLE;
			line_valid <= '0;
			seen_tag <= '0;
			rsp_tag <= '0;
			o_bus_request <= 1'b0;
		end
		else begin
			case (state)
				fetch_pkg::CACHE_IDLE: begin
					if (new_request) begin
						if (hit) begin
							seen_tag <= i_req.tag;
							rsp_tag <= i_req.tag;
						end
						else begin
							o_bus_request <= 1'b1;
							state <= fetch_pkg::CACHE_FILL;
						end
					end
				end
				fetch_pkg::CACHE_FILL: begin
					// ready is a single-cycle pulse, drop the request on it
					if (i_bus_ready) begin
						line_valid[fill_index] <= 1'b1;
						o_bus_request <= 1'b0;
						state <= fetch_pkg::CACHE_IDLE;
					end
				end
				default: begin
					state <= fetch_pkg::CACHE_IDLE;
				end
			endcase
		end
	end

	// payload: line contents, response word and fill address
	// after a fill the tag is still unanswered, so the next cycle hits
	always_ff @(posedge i_clock) begin
		if (state == fetch_pkg::CACHE_IDLE && new_request) begin
			if (hit) begin
				rsp_data <= line_data[req_index];
			end
			else begin
				o_bus_address <= {i_req.address[fetch_pkg::XLEN-1:INDEX_LSB],
					{fetch_pkg::ICACHE_OFFSET_WIDTH{1'b0}}};
			end
		end
		if (state == fetch_pkg::CACHE_FILL && i_bus_ready) begin
			line_data[fill_index] <= i_bus_rdata;
			line_tag[fill_index] <= fill_addr_tag;
		end
	end

endmodule

//--- fetch_stage.sv
module fetch_stage (
	input logic i_clock,
	input logic i_reset,
	input logic i_stall,

	// cache side
	output fetch_pkg::fetch_req_t o_req,
	input fetch_pkg::fetch_rsp_t i_rsp,

	// branch detector, fed from o_rsp_word in the same cycle
	input logic i_is_branch,
	output logic [31:0] o_rsp_word,

	// execute side
	input fetch_pkg::redirect_t i_redirect,
	output fetch_pkg::fetch_out_t o_fetch
);

	fetch_pkg::fetch_state_e state;
	logic [fetch_pkg::XLEN-1:0] pc;
	fetch_pkg::tag_t req_tag;
	logic rsp_match;
	logic redirect_match;

	// pc only moves on a match or a redirect, so the address holds
	// steady for as long as a request is in flight
	assign o_req.tag = req_tag;
	assign o_req.address = pc;

	assign o_rsp_word = i_rsp.data;

	assign rsp_match = (i_rsp.tag == req_tag);
	assign redirect_match = (i_redirect.tag == o_fetch.tag);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= fetch_pkg::FETCH_ISSUE;
			pc <= '0;
			req_tag <= '0;
			o_fetch <= '0;
		end
		else begin
			case (state)
				fetch_pkg::FETCH_ISSUE: begin
					// stall only blocks new requests
					if (!i_stall) begin
						req_tag <= fetch_pkg::tag_t'(req_tag + 1'b1);
						state <= fetch_pkg::FETCH_WAIT;
					end
				end

				fetch_pkg::FETCH_WAIT: begin
					if (rsp_match) begin
						o_fetch.tag <= i_rsp.tag;
						o_fetch.instruction <= i_rsp.data;
						o_fetch.pc <= pc;
						pc <= pc + fetch_pkg::XLEN'(fetch_pkg::INSTR_BYTES);
						// no fetching past a control transfer
						if (i_is_branch) begin
							state <= fetch_pkg::FETCH_BRANCH;
						end
						else begin
							state <= fetch_pkg::FETCH_ISSUE;
						end
					end
				end

				fetch_pkg::FETCH_BRANCH: begin
					// redirects for any other tag are dropped
					if (redirect_match) begin
						pc <= i_redirect.pc_next;
						state <= fetch_pkg::FETCH_ISSUE;
					end
				end

				default: begin
					state <= fetch_pkg::FETCH_ISSUE;
				end
			endcase
		end
	end

endmodule

//--- fetch_unit.sv
module fetch_unit (
	input logic i_clock,
	input logic i_reset,
	input logic i_stall,

	// execute side
	input fetch_pkg::redirect_t i_redirect,
	output fetch_pkg::fetch_out_t o_fetch,

	// word bus
	output logic o_bus_request,
	output logic [31:0] o_bus_address,
	input logic i_bus_ready,
	input logic [31:0] i_bus_rdata
);

	fetch_pkg::fetch_req_t req;
	fetch_pkg::fetch_rsp_t rsp;
	logic [31:0] rsp_word;
	logic is_branch;

	fetch_stage u_stage (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_stall(i_stall),
		.o_req(req),
		.i_rsp(rsp),
		.i_is_branch(is_branch),
		.o_rsp_word(rsp_word),
		.i_redirect(i_redirect),
		.o_fetch(o_fetch)
	);

	fetch_icache u_icache (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_req(req),
		.o_rsp(rsp),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata)
	);

	// classifies the response word while the stage checks the tag
	fetch_branch_detect u_branch_detect (
		.i_instruction(rsp_word),
		.o_is_branch(is_branch)
	);

endmodule

//--- tb_bus_memory.sv
module tb_bus_memory (
	input logic i_clock,
	input logic i_reset,
	input logic i_request,
	input logic [31:0] i_address,
	output logic o_ready,
	output logic [31:0] o_rdata,
	output int o_request_count
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int WORDS = 64;
	localparam int MAX_LATENCY = 4;
	localparam logic [31:0] SEED = 32'd25;

	logic [31:0] image [WORDS];
	logic [31:0] rng;
	logic busy;
	int wait_left;
	logic [31:0] held_address;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// addi-type filler, so no unused word looks like a control transfer
	function automatic logic [31:0] fill_word(input logic [31:0] address);
		return {address[31:7] ^ address[26:2], 7'h13};
	endfunction

	function automatic logic [31:0] read_word(input logic [31:0] address);
		if (address < 32'(WORDS * 4)) begin
			return image[address[7:2]];
		end
		return fill_word(address);
	endfunction

	initial begin
		for (int i = 0; i < WORDS; i++) begin
			image[i] = fill_word(32'(i * 4));
		end
		// straight-line code, then the loop body from 0x0c to 0x18
		image[0] = 32'h00100093;
		image[1] = 32'h00200113;
		image[2] = 32'h00300193;
		image[3] = 32'h00108093;
		image[4] = 32'h00110113;
		image[5] = 32'h00218193;
		// conditional branch back to 0x0c
		image[6] = 32'hfe309ae3;
		image[7] = 32'h00000013;
		// jal to 0x40
		image[8] = 32'h0200006f;
		image[16] = 32'h00400213;
		image[17] = 32'h08000293;
		// jalr through x5 to 0x80
		image[18] = 32'h00028067;
		image[32] = 32'h00500313;
		image[33] = 32'h00600393;
		// jal to itself, never resolved
		image[34] = 32'h0000006f;
		o_ready = 1'b0;
		o_rdata = '0;
		o_request_count = 0;
		busy = 1'b0;
		wait_left = 0;
		held_address = '0;
		rng = SEED;
	end

	always begin
		logic req;
		logic [31:0] addr;
		@(posedge i_clock);
		req = i_request;
		addr = i_address;
		#0.5;
		if (i_reset) begin
			o_ready = 1'b0;
			busy = 1'b0;
		end
		else if (o_ready) begin
			// the request was still high at this edge, it drops now
			o_ready = 1'b0;
		end
		else if (busy) begin
			if (wait_left > 1) begin
				wait_left--;
			end
			else begin
				o_ready = 1'b1;
				o_rdata = read_word(held_address);
				busy = 1'b0;
			end
		end
		else if (req) begin
			rng = xorshift32(rng);
			wait_left = 1 + int'(rng % MAX_LATENCY);
			held_address = addr;
			busy = 1'b1;
			o_request_count++;
		end
	end

endmodule

//--- tb_fetch_unit.sv
module tb_fetch_unit;
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] SEED = 32'd25;
	localparam int NUM_FETCHES = 19;
	localparam int NUM_REDIRECTS = 4;
	localparam int WRONG_TAG_INDEX = 2;
	localparam int MAX_STALL = 4;
	// nine lines up to the jal and three each at 0x40 and 0x80 fill once
	localparam int EXPECTED_FILLS = 15;
	localparam int TIMEOUT_CYCLES = NUM_FETCHES * (3 + 4 + 5 + MAX_STALL) + 200;

	logic clock;
	logic reset;
	logic stall;
	fetch_pkg::redirect_t redirect;
	fetch_pkg::fetch_out_t fetch_out;
	logic bus_request;
	logic [31:0] bus_address;
	logic bus_ready;
	logic [31:0] bus_rdata;
	int request_count;

	// reference model of the fetch stream
	fetch_pkg::tag_t exp_tag;
	logic [31:0] exp_pc;
	logic [31:0] exp_word;
	logic branch_pending;
	logic second_pass;
	int fetch_count;
	logic done;

	logic reset_q = 1'b0;
	fetch_pkg::tag_t last_tag;
	logic fetch_seen;
	int stall_changes;
	int cycles = 0;
	logic [31:0] resp_rng = SEED;
	logic [31:0] stall_rng = SEED;

	int reset_errors = 0;
	int fetch_errors = 0;
	int branch_errors = 0;
	int bus_errors = 0;
	int stall_errors = 0;
	int final_errors = 0;

	fetch_unit DUT (
		.i_clock(clock),
		.i_reset(reset),
		.i_stall(stall),
		.i_redirect(redirect),
		.o_fetch(fetch_out),
		.o_bus_request(bus_request),
		.o_bus_address(bus_address),
		.i_bus_ready(bus_ready),
		.i_bus_rdata(bus_rdata)
	);

	tb_bus_memory memory (
		.i_clock(clock),
		.i_reset(reset),
		.i_request(bus_request),
		.i_address(bus_address),
		.o_ready(bus_ready),
		.o_rdata(bus_rdata),
		.o_request_count(request_count)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// jal, jalr and conditional branch major opcodes
	function automatic logic is_control(input logic [31:0] word);
		return word[6:0] == 7'b1101111 || word[6:0] == 7'b1100111 || word[6:0] == 7'b1100011;
	endfunction

	// loop taken, loop not taken, jal target, jalr target
	function automatic logic [31:0] resolved_target(input int index);
		case (index)
			0: return 32'h0000000c;
			1: return 32'h0000001c;
			2: return 32'h00000040;
			default: return 32'h00000080;
		endcase
	endfunction

	task automatic drive_redirect(input fetch_pkg::tag_t tag, input logic [31:0] pc_next);
		redirect.tag = tag;
		redirect.pc_next = pc_next;
	endtask

	always #2 clock = ~clock;

	assign exp_word = memory.image[exp_pc[7:2]];
	assign fetch_seen = (fetch_out.tag != last_tag);

	always @(posedge clock) begin
		reset_q <= reset;
		last_tag <= fetch_out.tag;
		if (reset || !stall) begin
			stall_changes <= 0;
		end
		else if (fetch_seen) begin
			stall_changes <= stall_changes + 1;
		end
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("timeout: the fetch stream did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation FAILED");
			$finish;
		end
	end

	reset_state: assert property (@(posedge clock) reset_q |-> !bus_request && fetch_out == '0)
	else begin
		reset_errors++;
		$display("ERROR %0t: outputs not cleared by reset", $time);
	end

	idle_output: assert property (@(posedge clock) disable iff (reset)
		fetch_count == 0 && !fetch_seen |-> fetch_out == '0)
	else begin
		reset_errors++;
		$display("ERROR %0t: fetch output not zero before the first fetch", $time);
	end

	tag_order: assert property (@(posedge clock) disable iff (reset)
		fetch_seen |-> fetch_out.tag == exp_tag)
	else begin
		fetch_errors++;
		$display("ERROR %0t: tag %0d, expected %0d", $time, $sampled(fetch_out.tag),
			$sampled(exp_tag));
	end

	pc_order: assert property (@(posedge clock) disable iff (reset)
		fetch_seen |-> fetch_out.pc == exp_pc)
	else begin
		fetch_errors++;
		$display("ERROR %0t: pc %h, expected %h", $time, $sampled(fetch_out.pc),
			$sampled(exp_pc));
	end

	word_match: assert property (@(posedge clock) disable iff (reset)
		fetch_seen |-> fetch_out.instruction == exp_word)
	else begin
		fetch_errors++;
		$display("ERROR %0t: instruction %h, expected %h", $time,
			$sampled(fetch_out.instruction), $sampled(exp_word));
	end

	branch_hold: assert property (@(posedge clock) disable iff (reset)
		branch_pending |-> !fetch_seen)
	else begin
		branch_errors++;
		$display("ERROR %0t: new fetch before the branch was resolved", $time);
	end

	bus_stable: assert property (@(posedge clock) disable iff (reset)
		bus_request && $past(bus_request) |-> $stable(bus_address))
	else begin
		bus_errors++;
		$display("ERROR %0t: bus address moved during a request", $time);
	end

	bus_aligned: assert property (@(posedge clock) disable iff (reset)
		bus_request |-> bus_address[1:0] == 2'b00)
	else begin
		bus_errors++;
		$display("ERROR %0t: bus address %h not word aligned", $time, $sampled(bus_address));
	end

	loop_hits: assert property (@(posedge clock) disable iff (reset)
		second_pass |-> !bus_request)
	else begin
		bus_errors++;
		$display("ERROR %0t: bus request on the second pass of the loop", $time);
	end

	stall_limit: assert property (@(posedge clock) disable iff (reset)
		stall && fetch_seen |-> stall_changes == 0)
	else begin
		stall_errors++;
		$display("ERROR %0t: more than one fetch during a stall", $time);
	end

	// execute side follows the stream and resolves control transfers
	initial begin
		logic [31:0] word;
		fetch_pkg::tag_t cur_tag;
		int delay;
		int ctl_count;
		exp_tag = 4'd1;
		exp_pc = '0;
		branch_pending = 1'b0;
		second_pass = 1'b0;
		fetch_count = 0;
		done = 1'b0;
		ctl_count = 0;
		@(negedge reset);
		while (!done) begin
			@(posedge clock);
			if (fetch_seen) begin
				word = exp_word;
				cur_tag = exp_tag;
				fetch_count++;
				exp_tag = fetch_pkg::tag_t'(exp_tag + 1'b1);
				if (!is_control(word)) begin
					exp_pc = exp_pc + 32'd4;
				end
				else if (ctl_count == NUM_REDIRECTS) begin
					// the last jal is left hanging to end the stream
					branch_pending = 1'b1;
					done = 1'b1;
				end
				else begin
					branch_pending = 1'b1;
					exp_pc = resolved_target(ctl_count);
					if (ctl_count == 1) begin
						second_pass = 1'b0;
					end
					resp_rng = xorshift32(resp_rng);
					delay = int'(resp_rng % 6);
					repeat (delay) @(posedge clock);
					if (ctl_count == WRONG_TAG_INDEX) begin
						#0.5 drive_redirect(fetch_pkg::tag_t'(cur_tag + 4'd3), 32'h00000100);
						@(posedge clock);
					end
					#0.5 drive_redirect(cur_tag, resolved_target(ctl_count));
					@(posedge clock);
					branch_pending = 1'b0;
					if (ctl_count == 0) begin
						second_pass = 1'b1;
					end
					ctl_count++;
				end
				#0.5 drive_redirect(fetch_pkg::tag_t'(cur_tag - 1'b1), '0);
			end
		end
	end

	// short random stall windows
	initial begin
		int gap;
		int len;
		@(negedge reset);
		while (!done) begin
			stall_rng = xorshift32(stall_rng);
			gap = 3 + int'(stall_rng % 12);
			len = 1 + int'((stall_rng >> 8) % MAX_STALL);
			repeat (gap) @(posedge clock);
			#0.5 stall = 1'b1;
			repeat (len) @(posedge clock);
			#0.5 stall = 1'b0;
		end
	end

	initial begin
		int total;
		clock = 1'b0;
		reset = 1'b1;
		stall = 1'b0;
		drive_redirect(4'hf, '0);
		repeat (4) @(posedge clock);
		#0.5 reset = 1'b0;
		wait (done);
		// the final jal must hold the stream
		repeat (20) @(posedge clock);
		fill_count: assert (request_count == EXPECTED_FILLS)
		else begin
			final_errors++;
			$display("ERROR %0t: %0d bus requests, expected %0d", $time, request_count,
				EXPECTED_FILLS);
		end
		total = reset_errors + fetch_errors + branch_errors + bus_errors + stall_errors
			+ final_errors;
		$display("error counts: reset %0d fetch %0d branch %0d bus %0d stall %0d final %0d",
			reset_errors, fetch_errors, branch_errors, bus_errors, stall_errors, final_errors);
		if (total == 0) begin
			$display("Simulation PASSED");
		end
		else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

//--- project.f
fetch_pkg.sv
fetch_branch_detect.sv
fetch_icache.sv
fetch_stage.sv
fetch_unit.sv
tb_bus_memory.sv
tb_fetch_unit.sv

//--- Bender.yml
package:
  name: fetch_unit

sources:
  - fetch_pkg.sv
  - fetch_branch_detect.sv
  - fetch_icache.sv
  - fetch_stage.sv
  - fetch_unit.sv
  - target: test
    files:
      - tb_bus_memory.sv
      - tb_fetch_unit.sv
